// ==== logic/rvx_io_pkg.sv ====
// --------------------
// Address map of the IO peripheral block: eight 32-byte regions, only 0 and 1 mapped
// Register offsets are word indices taken from offset bits 4:2
// --------------------
package rvx_io_pkg;

  // Bus types
  typedef logic [7:0]  io_address_t;
  typedef logic [31:0] io_data_t;
  typedef logic [3:0]  io_strobe_t;

  // Byte offset inside one region
  typedef logic [4:0] peripheral_address_t;

  // Port pin vector
  typedef logic [31:0] gpio_word_t;

  // Region select bits of io_address_t
  localparam int REGION_MSB = 7;
  localparam int REGION_LSB = 5;

  // Region numbers, all others unmapped
  localparam logic [2:0] REGION_TIMER = 3'd0;
  localparam logic [2:0] REGION_GPIO  = 3'd1;

  // Timer register word indices
  localparam logic [2:0] TIMER_REG_CR        = 3'd0;
  localparam logic [2:0] TIMER_REG_MTIMEL    = 3'd1;
  localparam logic [2:0] TIMER_REG_MTIMEH    = 3'd2;
  localparam logic [2:0] TIMER_REG_MTIMECMPL = 3'd3;
  localparam logic [2:0] TIMER_REG_MTIMECMPH = 3'd4;

  // Port register word indices
  localparam logic [2:0] GPIO_REG_OUT = 3'd0;
  localparam logic [2:0] GPIO_REG_IN  = 3'd1;

endpackage

// ==== logic/rvx_io_decoder.sv ====
// --------------------
// Reads and writes must never be requested in the same cycle
// Unmapped accesses get a response one clock later, reads return zero
// --------------------
`timescale 1ns/1ps

module rvx_io_decoder (
  input  logic                   clock,
  input  logic                   reset_n,
  input  rvx_io_pkg::io_address_t address,
  input  logic                   read_request,
  input  logic                   write_request,
  output logic                   timer_read_request,
  output logic                   timer_write_request,
  output logic                   gpio_read_request,
  output logic                   gpio_write_request,
  input  rvx_io_pkg::io_data_t   timer_read_data,
  input  rvx_io_pkg::io_data_t   gpio_read_data,
  input  logic                   timer_read_response,
  input  logic                   timer_write_response,
  input  logic                   gpio_read_response,
  input  logic                   gpio_write_response,
  output rvx_io_pkg::io_data_t   read_data,
  output logic                   read_response,
  output logic                   write_response
);

  logic [rvx_io_pkg::REGION_MSB-rvx_io_pkg::REGION_LSB:0] region;
  logic region_timer;
  logic region_gpio;
  logic region_mapped;
  logic unmapped_read;
  logic unmapped_write;

  assign region        = address[rvx_io_pkg::REGION_MSB:rvx_io_pkg::REGION_LSB];
  assign region_timer  = (region == rvx_io_pkg::REGION_TIMER);
  assign region_gpio   = (region == rvx_io_pkg::REGION_GPIO);
  assign region_mapped = region_timer | region_gpio;

  // Steer the strobes to the selected peripheral only
  assign timer_read_request  = read_request & region_timer;
  assign timer_write_request = write_request & region_timer;
  assign gpio_read_request   = read_request & region_gpio;
  assign gpio_write_request  = write_request & region_gpio;

  // Decoder answers unmapped regions on its own
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      unmapped_read  <= 1'b0;
      unmapped_write <= 1'b0;
    end else begin
      unmapped_read  <= read_request & ~region_mapped;
      unmapped_write <= write_request & ~region_mapped;
    end
  end

  // Merge responses; unmapped read falls through to zero
  always_comb begin
    if (timer_read_response) begin
      read_data = timer_read_data;
    end else if (gpio_read_response) begin
      read_data = gpio_read_data;
    end else begin
      read_data = '0;
    end
  end

  assign read_response  = timer_read_response | gpio_read_response | unmapped_read;
  assign write_response = timer_write_response | gpio_write_response | unmapped_write;

  a_single_target: assert property (@(posedge clock) disable iff (!reset_n)
    $onehot0({timer_read_request, timer_write_request, gpio_read_request, gpio_write_request}));

  a_read_answered: assert property (@(posedge clock) disable iff (!reset_n)
    read_request |=> read_response);

  a_write_answered: assert property (@(posedge clock) disable iff (!reset_n)
    write_request |=> write_response);

endmodule

// ==== logic/rvx_timer.sv ====
// --------------------
// Only aligned full-word writes take effect and all others are dropped silently
// Misaligned or unknown reads return zero
// --------------------
`timescale 1ns/1ps

module rvx_timer (
  input  logic                           clock,
  input  logic                           reset_n,
  input  rvx_io_pkg::peripheral_address_t rw_address,
  output rvx_io_pkg::io_data_t           read_data,
  input  logic                           read_request,
  output logic                           read_response,
  input  rvx_io_pkg::io_data_t           write_data,
  input  rvx_io_pkg::io_strobe_t         write_strobe,
  input  logic                           write_request,
  output logic                           write_response,
  output logic                           irq
);

  logic [2:0]  reg_index;
  logic        address_aligned;
  logic        write_accepted;

  logic        cr_update;
  logic        mtime_l_update;
  logic        mtime_h_update;
  logic        mtimecmp_l_update;
  logic        mtimecmp_h_update;
  logic        compare_hold;

  logic        cr_en;
  logic [63:0] mtime;
  logic [63:0] mtime_step;
  logic [63:0] mtimecmp;

  assign reg_index       = rw_address[4:2];
  assign address_aligned = (rw_address[1:0] == 2'b00);
  assign write_accepted  = write_request & address_aligned & (&write_strobe);

  // Register write decode
  always_comb begin
    cr_update         = 1'b0;
    mtime_l_update    = 1'b0;
    mtime_h_update    = 1'b0;
    mtimecmp_l_update = 1'b0;
    mtimecmp_h_update = 1'b0;
    if (write_accepted) begin
      case (reg_index)
        rvx_io_pkg::TIMER_REG_CR:        cr_update = 1'b1;
        rvx_io_pkg::TIMER_REG_MTIMEL:    mtime_l_update = 1'b1;
        rvx_io_pkg::TIMER_REG_MTIMEH:    mtime_h_update = 1'b1;
        rvx_io_pkg::TIMER_REG_MTIMECMPL: mtimecmp_l_update = 1'b1;
        rvx_io_pkg::TIMER_REG_MTIMECMPH: mtimecmp_h_update = 1'b1;
        default: ;
      endcase
    end
  end

  assign compare_hold = mtime_l_update | mtime_h_update |
                        mtimecmp_l_update | mtimecmp_h_update;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      cr_en <= 1'b0;
    end else if (cr_update) begin
      cr_en <= write_data[0];
    end
  end

  // Half not being written keeps counting
  assign mtime_step = cr_en ? mtime + 64'd1 : mtime;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mtime <= '0;
    end else if (mtime_l_update) begin
      mtime <= {mtime_step[63:32], write_data};
    end else if (mtime_h_update) begin
      mtime <= {write_data, mtime_step[31:0]};
    end else begin
      mtime <= mtime_step;
    end
  end

  // All ones at reset keeps irq quiet until software programs it
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mtimecmp <= '1;
    end else begin
      if (mtimecmp_l_update) begin
        mtimecmp[31:0] <= write_data;
      end
      if (mtimecmp_h_update) begin
        mtimecmp[63:32] <= write_data;
      end
    end
  end

  // Level interrupt frozen while either operand is written
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      irq <= 1'b0;
    end else if (!compare_hold) begin
      irq <= (mtime >= mtimecmp);
    end
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  // Read data only meaningful alongside read_response
  always_ff @(posedge clock) begin
    if (read_request) begin
      read_data <= '0;
      if (address_aligned) begin
        case (reg_index)
          rvx_io_pkg::TIMER_REG_CR:        read_data <= rvx_io_pkg::io_data_t'(cr_en);
          rvx_io_pkg::TIMER_REG_MTIMEL:    read_data <= mtime[31:0];
          rvx_io_pkg::TIMER_REG_MTIMEH:    read_data <= mtime[63:32];
          rvx_io_pkg::TIMER_REG_MTIMECMPL: read_data <= mtimecmp[31:0];
          rvx_io_pkg::TIMER_REG_MTIMECMPH: read_data <= mtimecmp[63:32];
          default: ;
        endcase
      end
    end
  end

  // Full-word aligned bus write to any mtime or mtimecmp half
  a_irq_held: assert property (@(posedge clock) disable iff (!reset_n)
    (write_request && rw_address[1:0] == 2'b00 && write_strobe == 4'hf &&
     rw_address[4:2] >= rvx_io_pkg::TIMER_REG_MTIMEL &&
     rw_address[4:2] <= rvx_io_pkg::TIMER_REG_MTIMECMPH) |=> $stable(irq));

endmodule

// ==== logic/rvx_gpio.sv ====
// --------------------
// gpio_in is sampled through two flops, so a change reads back from the third clock
// --------------------
`timescale 1ns/1ps

module rvx_gpio (
  input  logic                           clock,
  input  logic                           reset_n,
  input  rvx_io_pkg::peripheral_address_t rw_address,
  output rvx_io_pkg::io_data_t           read_data,
  input  logic                           read_request,
  output logic                           read_response,
  input  rvx_io_pkg::io_data_t           write_data,
  input  rvx_io_pkg::io_strobe_t         write_strobe,
  input  logic                           write_request,
  output logic                           write_response,
  input  rvx_io_pkg::gpio_word_t         gpio_in,
  output rvx_io_pkg::gpio_word_t         gpio_out
);

  logic [2:0]             reg_index;
  logic                   address_aligned;
  logic                   out_write;
  rvx_io_pkg::gpio_word_t gpio_in_meta;
  rvx_io_pkg::gpio_word_t gpio_in_sync;

  assign reg_index       = rw_address[4:2];
  assign address_aligned = (rw_address[1:0] == 2'b00);
  assign out_write       = write_request & address_aligned &
                           (reg_index == rvx_io_pkg::GPIO_REG_OUT);

  // Byte lanes follow write_strobe
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      gpio_out <= '0;
    end else if (out_write) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (write_strobe[lane]) begin
          gpio_out[8*lane +: 8] <= write_data[8*lane +: 8];
        end
      end
    end
  end

  // Two-flop synchronizer
  always_ff @(posedge clock) begin
    gpio_in_meta <= gpio_in;
    gpio_in_sync <= gpio_in_meta;
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  always_ff @(posedge clock) begin
    if (read_request) begin
      read_data <= '0;
      if (address_aligned && reg_index == rvx_io_pkg::GPIO_REG_OUT) begin
        read_data <= gpio_out;
      end else if (address_aligned && reg_index == rvx_io_pkg::GPIO_REG_IN) begin
        read_data <= gpio_in_sync;
      end
    end
  end

endmodule

// ==== logic/rvx_io_subsystem.sv ====
// --------------------
// Peripheral block on the plain IO bus, one-cycle response in every region
// --------------------
`timescale 1ns/1ps

module rvx_io_subsystem (
  input  logic                    clock,
  input  logic                    reset_n,
  input  rvx_io_pkg::io_address_t address,
  input  rvx_io_pkg::io_data_t    write_data,
  input  rvx_io_pkg::io_strobe_t  write_strobe,
  input  logic                    read_request,
  input  logic                    write_request,
  output rvx_io_pkg::io_data_t    read_data,
  output logic                    read_response,
  output logic                    write_response,
  output logic                    irq,
  input  rvx_io_pkg::gpio_word_t  gpio_in,
  output rvx_io_pkg::gpio_word_t  gpio_out
);

  logic                 timer_read_request;
  logic                 timer_write_request;
  logic                 gpio_read_request;
  logic                 gpio_write_request;
  rvx_io_pkg::io_data_t timer_read_data;
  rvx_io_pkg::io_data_t gpio_read_data;
  logic                 timer_read_response;
  logic                 timer_write_response;
  logic                 gpio_read_response;
  logic                 gpio_write_response;

  rvx_io_decoder i_rvx_io_decoder (
    .clock                (clock),
    .reset_n              (reset_n),
    .address              (address),
    .read_request         (read_request),
    .write_request        (write_request),
    .timer_read_request   (timer_read_request),
    .timer_write_request  (timer_write_request),
    .gpio_read_request    (gpio_read_request),
    .gpio_write_request   (gpio_write_request),
    .timer_read_data      (timer_read_data),
    .gpio_read_data       (gpio_read_data),
    .timer_read_response  (timer_read_response),
    .timer_write_response (timer_write_response),
    .gpio_read_response   (gpio_read_response),
    .gpio_write_response  (gpio_write_response),
    .read_data            (read_data),
    .read_response        (read_response),
    .write_response       (write_response)
  );

  // Offset is the low address bits below the region field
  rvx_timer i_rvx_timer (
    .clock          (clock),
    .reset_n        (reset_n),
    .rw_address     (address[rvx_io_pkg::REGION_LSB-1:0]),
    .read_data      (timer_read_data),
    .read_request   (timer_read_request),
    .read_response  (timer_read_response),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .write_request  (timer_write_request),
    .write_response (timer_write_response),
    .irq            (irq)
  );

  rvx_gpio i_rvx_gpio (
    .clock          (clock),
    .reset_n        (reset_n),
    .rw_address     (address[rvx_io_pkg::REGION_LSB-1:0]),
    .read_data      (gpio_read_data),
    .read_request   (gpio_read_request),
    .read_response  (gpio_read_response),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .write_request  (gpio_write_request),
    .write_response (gpio_write_response),
    .gpio_in        (gpio_in),
    .gpio_out       (gpio_out)
  );

endmodule

// ==== verification/rvx_io_subsystem_tb.sv ====
// --------------------
// Self-checking testbench that issues one bus access at a time from a fixed LFSR seed
// --------------------
`timescale 1ns/1ps

module rvx_io_subsystem_tb;

  localparam int CLOCK_PERIOD     = 20;
  localparam int RESET_CYCLES     = 10;
  localparam int RESPONSE_TIMEOUT = 4;
  localparam int IRQ_WAIT         = 64;
  // Run budget of about 54 bus accesses plus the idle waits
  localparam int BUS_OPS          = 60;
  localparam int BUS_OP_CYCLES    = 3;
  localparam int WAIT_CYCLES      = 90;
  localparam int TEST_CYCLES      = RESET_CYCLES + BUS_OPS * BUS_OP_CYCLES + WAIT_CYCLES;
  localparam int WATCHDOG_NS      = TEST_CYCLES * CLOCK_PERIOD * 2;

  logic                    clock;
  logic                    reset_n;
  rvx_io_pkg::io_address_t address;
  rvx_io_pkg::io_data_t    write_data;
  rvx_io_pkg::io_strobe_t  write_strobe;
  logic                    read_request;
  logic                    write_request;
  rvx_io_pkg::io_data_t    read_data;
  logic                    read_response;
  logic                    write_response;
  logic                    irq;
  rvx_io_pkg::gpio_word_t  gpio_in;
  rvx_io_pkg::gpio_word_t  gpio_out;

  logic [31:0] lfsr_state;
  string       test_name;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;

  // Reference state kept from the register rules
  logic [31:0] gpio_model;
  logic [31:0] cr_model;
  logic [31:0] cmpl_model;
  logic [31:0] cmph_model;
  logic [31:0] value;
  logic [31:0] first;
  logic [31:0] second;
  logic [31:0] hi;
  logic [31:0] lo;
  logic [3:0]  strobe;
  int          waited;

  rvx_io_subsystem i_rvx_io_subsystem (
    .clock          (clock),
    .reset_n        (reset_n),
    .address        (address),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_request   (read_request),
    .write_request  (write_request),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .irq            (irq),
    .gpio_in        (gpio_in),
    .gpio_out       (gpio_out)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  a_read_next_clock: assert property (@(posedge clock) disable iff (!reset_n)
    read_request |=> read_response)
    else begin
      $display("read request at address %h got no response on the next clock", $past(address));
      errors++;
    end

  a_write_next_clock: assert property (@(posedge clock) disable iff (!reset_n)
    write_request |=> write_response)
    else begin
      $display("write request at address %h got no response on the next clock", $past(address));
      errors++;
    end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic rvx_io_pkg::io_address_t reg_address(input logic [2:0] region,
                                                          input logic [2:0] index);
    return {region, index, 2'b00};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic bus_write(input rvx_io_pkg::io_address_t addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int cycles;
    cycles = 0;
    @(posedge clock);
    address       <= addr;
    write_data    <= data;
    write_strobe  <= strb;
    write_request <= 1'b1;
    @(posedge clock);
    write_request <= 1'b0;
    @(negedge clock);
    while (!write_response && cycles < RESPONSE_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!write_response) begin
      $display("write to address %h was never answered by the DUT", addr);
      errors++;
    end
  endtask

  task automatic bus_read(input rvx_io_pkg::io_address_t addr, output logic [31:0] data);
    int cycles;
    cycles = 0;
    @(posedge clock);
    address      <= addr;
    read_request <= 1'b1;
    @(posedge clock);
    read_request <= 1'b0;
    @(negedge clock);
    while (!read_response && cycles < RESPONSE_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    data = read_data;
    if (!read_response) begin
      $display("read from address %h was never answered by the DUT", addr);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) begin
      $display("test %s: passed", test_name);
    end else begin
      $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
      tests_failed++;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    clock         = 1'b0;
    reset_n       = 1'b0;
    address       = '0;
    write_data    = '0;
    write_strobe  = '0;
    read_request  = 1'b0;
    write_request = 1'b0;
    gpio_in       = '0;
    lfsr_state    = 32'heb45_5de1;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    gpio_model    = '0;
    cr_model      = '0;
    cmpl_model    = 32'hffff_ffff;
    cmph_model    = 32'hffff_ffff;
    repeat (RESET_CYCLES) @(posedge clock);
    reset_n <= 1'b1;

    start_test("reset_state");
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_CR), value);
    check_value("cr", cr_model, value);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPL), value);
    check_value("mtimecmp low", cmpl_model, value);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPH), value);
    check_value("mtimecmp high", cmph_model, value);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEL), value);
    check_value("mtime low", 32'h0, value);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEH), value);
    check_value("mtime high", 32'h0, value);
    check_value("irq", 32'h0, {31'b0, irq});
    check_value("gpio_out", 32'h0, gpio_out);
    finish_test();

    // Disabled timer holds whatever is written
    start_test("counter");
    lo = random_bits(32);
    hi = random_bits(32);
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEL), lo, 4'hf);
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEH), hi, 4'hf);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEL), value);
    check_value("mtime low readback", lo, value);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEH), value);
    check_value("mtime high readback", hi, value);
    // Low half restarts near zero so the count cannot wrap
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEL), 32'h0, 4'hf);
    cr_model = 32'h1;
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_CR), cr_model, 4'hf);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEL), first);
    repeat (5) @(posedge clock);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEL), second);
    checks++;
    assert (second > first)
    else begin
      $display("FAILED %s mtime advance: expected above %h, actual %h", test_name, first, second);
      errors++;
    end
    finish_test();

    start_test("interrupt");
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEH), hi);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMEL), lo);
    cmpl_model = lo + 32'd30;
    cmph_model = hi;
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPL),
              cmpl_model, 4'hf);
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPH),
              cmph_model, 4'hf);
    waited = 0;
    while (!irq && waited < IRQ_WAIT) begin
      @(negedge clock);
      waited++;
    end
    check_value("irq raised", 32'h1, {31'b0, irq});
    cmph_model = 32'hffff_ffff;
    cmpl_model = 32'hffff_ffff;
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPH),
              cmph_model, 4'hf);
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPL),
              cmpl_model, 4'hf);
    @(negedge clock);
    check_value("irq cleared", 32'h0, {31'b0, irq});
    finish_test();

    // Partial and misaligned writes are dropped
    start_test("timer_write_rules");
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPL),
              random_bits(32), 4'b0011);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPL), value);
    check_value("partial strobe", cmpl_model, value);
    bus_write(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPL) + 8'd2,
              random_bits(32), 4'hf);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPL), value);
    check_value("misaligned", cmpl_model, value);
    finish_test();

    start_test("port");
    for (int n = 0; n < 12; n++) begin
      value  = random_bits(32);
      strobe = 4'(random_bits(4));
      for (int lane = 0; lane < 4; lane++) begin
        if (strobe[lane]) begin
          gpio_model[8*lane +: 8] = value[8*lane +: 8];
        end
      end
      bus_write(reg_address(rvx_io_pkg::REGION_GPIO, rvx_io_pkg::GPIO_REG_OUT), value, strobe);
      check_value("gpio_out", gpio_model, gpio_out);
    end
    bus_read(reg_address(rvx_io_pkg::REGION_GPIO, rvx_io_pkg::GPIO_REG_OUT), value);
    check_value("out register", gpio_model, value);
    for (int n = 0; n < 2; n++) begin
      @(posedge clock);
      gpio_in <= random_bits(32);
      repeat (3) @(posedge clock);
      bus_read(reg_address(rvx_io_pkg::REGION_GPIO, rvx_io_pkg::GPIO_REG_IN), value);
      check_value("in register", gpio_in, value);
    end
    finish_test();

    start_test("unmapped");
    for (int region = 2; region < 8; region++) begin
      bus_read(reg_address(region[2:0], 3'(random_bits(3))), value);
      check_value("unmapped read", 32'h0, value);
    end
    // Offsets that would hit live registers in a mapped region
    for (int region = 2; region < 8; region++) begin
      bus_write(reg_address(region[2:0], 3'((region - 2) % 5)), random_bits(32), 4'hf);
    end
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_CR), value);
    check_value("cr", cr_model, value);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPL), value);
    check_value("mtimecmp low", cmpl_model, value);
    bus_read(reg_address(rvx_io_pkg::REGION_TIMER, rvx_io_pkg::TIMER_REG_MTIMECMPH), value);
    check_value("mtimecmp high", cmph_model, value);
    bus_read(reg_address(rvx_io_pkg::REGION_GPIO, rvx_io_pkg::GPIO_REG_OUT), value);
    check_value("out register", gpio_model, value);
    check_value("gpio_out", gpio_model, gpio_out);
    finish_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
logic/rvx_io_pkg.sv
logic/rvx_io_decoder.sv
logic/rvx_timer.sv
logic/rvx_gpio.sv
logic/rvx_io_subsystem.sv
verification/rvx_io_subsystem_tb.sv
